/* hw/obj_params.svh */
`ifndef OBJ_PARAMS_SVH
`define OBJ_PARAMS_SVH

// object table depth
`define OBJ_COUNT 32

// object size, one graphics row per line
`define OBJ_HEIGHT 16
`define OBJ_WIDTH 8

// entries per line buffer bank
`define LINE_W 256

// x shift so the buffer lines up with hdump
`define OBJ_HOFFSET 6

`endif

/* hw/obj_video_pkg.sv */
package obj_video_pkg;

    // column or line number
    typedef logic [7:0] hpos_t;

    // palette PROM output, 0 = no object here
    typedef logic [7:0] color_t;

    // one pixel write into the line buffer
    typedef struct packed {
        hpos_t      addr; // buffer column
        logic [3:0] pix;  // pixel index, 0 is transparent
        logic [3:0] pal;  // palette bank
        logic       we;
    } buf_wr_t;

endpackage

/* hw/obj_gfx_pkg.sv */
package obj_gfx_pkg;

    // object table entry as stored in RAM
    typedef struct packed {
        logic [7:0] ypos;  // top line
        logic [7:0] xpos;  // left column
        logic [7:0] code;  // graphics code
        logic [3:0] pal;
        logic       hflip;
        logic       vflip;
        logic [1:0] spare; // unused by the engine
    } obj_entry_t;

    // scan -> draw, one object on the current line
    typedef struct packed {
        logic [7:0] xpos;
        logic [7:0] code;
        logic [3:0] pal;
        logic       hflip;
        logic [3:0] ysub;  // row inside object, vflip already applied
    } draw_req_t;

    // code in the upper byte, row in the low nibble
    typedef logic [11:0] rom_addr_t;

    // eight pixels, pixel i in nibble i
    typedef logic [31:0] rom_row_t;

endpackage

/* hw/obj_scan.sv */
`include "obj_params.svh"

module obj_scan (
    input  logic                             clk,
    input  logic                             rst,

    // table write port
    input  logic                             obj_we,
    input  logic [$clog2(`OBJ_COUNT)-1:0]    obj_addr,
    input  obj_gfx_pkg::obj_entry_t          obj_din,

    // line timing
    input  logic                             hinit,
    input  obj_video_pkg::hpos_t             vrender,

    // handshake with obj_draw
    input  logic                             busy,
    output logic                             draw,
    output obj_gfx_pkg::draw_req_t           req
);

    localparam int IW = $clog2(`OBJ_COUNT);

    obj_gfx_pkg::obj_entry_t table_mem [`OBJ_COUNT]; // object table RAM

    logic [IW-1:0]            idx;     // entry under test
    logic                     active;  // scan running for this line
    obj_gfx_pkg::obj_entry_t  ent;
    obj_video_pkg::hpos_t     row;     // line minus top, wraps
    logic                     hit;
    logic                     advance; // move on to the next entry
    logic                     issue;   // hand the hit to obj_draw

    always_ff @(posedge clk) begin
        if (obj_we) begin
            table_mem[obj_addr] <= obj_din;
        end
    end

    assign ent = table_mem[idx]; // async read, one entry per cycle
    assign row = vrender - ent.ypos;
    assign hit = active && (row < 8'(`OBJ_HEIGHT));

    // draw is still high on the cycle before busy rises, so wait that one out
    assign issue   = hit && !busy && !draw;
    assign advance = active && (!hit || issue);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            idx    <= '0;
            draw   <= 1'b0;
        end else begin
            draw <= issue; // single cycle pulse
            if (hinit) begin
                active <= 1'b1; // restart at entry 0
                idx    <= '0;
            end else if (advance) begin
                idx <= idx + 1'b1;
                if (idx == IW'(`OBJ_COUNT - 1)) begin
                    active <= 1'b0; // whole table seen
                end
            end
        end
    end

    // request payload, only meaningful with draw
    always_ff @(posedge clk) begin
        if (issue) begin
            req.xpos  <= ent.xpos;
            req.code  <= ent.code;
            req.pal   <= ent.pal;
            req.hflip <= ent.hflip;
            req.ysub  <= row[3:0] ^ {4{ent.vflip}}; // 15-r when flipped
        end
    end

    // obj_draw must be idle whenever a new object is handed over
    a_draw_not_busy: assert property (@(posedge clk) disable iff (rst)
        draw |-> !busy);

endmodule

/* hw/obj_draw.sv */
`include "obj_params.svh"

module obj_draw (
    input  logic                       clk,
    input  logic                       rst,

    // from obj_scan
    input  logic                       draw,
    input  obj_gfx_pkg::draw_req_t     req,
    output logic                       busy,

    // graphics ROM
    output obj_gfx_pkg::rom_addr_t     rom_addr,
    output logic                       rom_cs,
    input  obj_gfx_pkg::rom_row_t      rom_data,
    input  logic                       rom_ok,

    // to the line buffer
    output obj_video_pkg::buf_wr_t     wr
);

    localparam int CW = $clog2(`OBJ_WIDTH);

    logic                      start;     // accepted request
    logic                      got_row;   // ROM answered
    logic                      shifting;  // pixel writes in progress
    logic [CW-1:0]             cnt;       // pixel number
    obj_gfx_pkg::rom_row_t     pixels;    // nibble 0 is the next pixel out
    obj_video_pkg::hpos_t      col;       // buffer column of next pixel
    obj_video_pkg::hpos_t      col_start;
    logic [3:0]                cur_pal;
    logic                      cur_hflip;

    assign start   = draw && !busy;
    assign got_row = rom_cs && rom_ok;

    // flipped objects start at the right edge and walk left
    assign col_start = req.xpos + 8'(`OBJ_HOFFSET)
                     + (req.hflip ? 8'(`OBJ_WIDTH - 1) : 8'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            rom_cs   <= 1'b0;
            shifting <= 1'b0;
            cnt      <= '0;
        end else begin
            if (start) begin
                busy   <= 1'b1;
                rom_cs <= 1'b1; // fetch right away
            end
            if (got_row) begin
                rom_cs   <= 1'b0;
                shifting <= 1'b1;
                cnt      <= '0;
            end
            if (shifting) begin
                cnt <= cnt + 1'b1;
                if (cnt == CW'(`OBJ_WIDTH - 1)) begin
                    shifting <= 1'b0; // last pixel written this cycle
                    busy     <= 1'b0;
                end
            end
        end
    end

    // request and row data
    always_ff @(posedge clk) begin
        if (start) begin
            rom_addr  <= {req.code, req.ysub};
            cur_pal   <= req.pal;
            cur_hflip <= req.hflip;
            col       <= col_start;
        end
        if (got_row) begin
            pixels <= rom_data;
        end else if (shifting) begin
            pixels <= pixels >> 4;
            col    <= cur_hflip ? col - 8'd1 : col + 8'd1; // wraps past 255
        end
    end

    always_comb begin
        wr.addr = col;
        wr.pix  = pixels[3:0];
        wr.pal  = cur_pal;
        wr.we   = shifting && (pixels[3:0] != 4'd0); // zero is see-through
    end

    // address and strobe held until the ROM answers
    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        (rom_cs && !rom_ok) |=> (rom_cs && $stable(rom_addr)));

endmodule

/* hw/obj_line_buf.sv */
`include "obj_params.svh"

module obj_line_buf (
    input  logic                      clk,
    input  logic                      rst,

    // pixel writes from obj_draw
    input  obj_video_pkg::buf_wr_t    wr,

    // palette PROM load
    input  logic                      prog_en,
    input  logic [7:0]                prog_addr,
    input  obj_video_pkg::color_t     prog_data,

    // video side
    input  logic                      hinit,
    input  obj_video_pkg::hpos_t      hdump,
    input  logic                      pxl_cen,
    output obj_video_pkg::color_t     pxl
);

    localparam int AW = $clog2(`LINE_W);

    obj_video_pkg::color_t pal_mem [256]; // palette PROM

    logic                  bank;       // bank being written, other one is read
    logic                  rd_sel;     // bank behind the read registers
    logic                  sweep;      // clearing both banks after reset
    logic [AW-1:0]         sweep_addr;
    logic                  we_q;       // write stage after palette lookup
    obj_video_pkg::hpos_t  addr_q;
    obj_video_pkg::color_t col_q;

    always_ff @(posedge clk) begin
        if (prog_en) begin
            pal_mem[prog_addr] <= prog_data;
        end
        col_q  <= pal_mem[{wr.pal, wr.pix}]; // lookup stage
        addr_q <= wr.addr;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank       <= 1'b0;
            rd_sel     <= 1'b1;
            sweep      <= 1'b1;
            sweep_addr <= '0;
            we_q       <= 1'b0;
        end else begin
            we_q   <= wr.we;
            rd_sel <= ~bank;
            if (hinit) begin
                bank <= ~bank; // new line goes into the bank just read out
            end
            if (sweep) begin
                sweep_addr <= sweep_addr + 1'b1;
                if (sweep_addr == AW'(`LINE_W - 1)) begin
                    sweep <= 1'b0;
                end
            end
        end
    end

    // one write port per bank, muxed between sweep, draw and erase
    for (genvar b = 0; b < 2; b++) begin : g_bank
        obj_video_pkg::color_t mem [`LINE_W];
        obj_video_pkg::color_t rd;

        always_ff @(posedge clk) begin
            if (sweep) begin
                mem[sweep_addr] <= '0;
            end else if (we_q && (bank == 1'(b))) begin
                mem[addr_q] <= col_q;
            end else if (pxl_cen && (bank != 1'(b))) begin
                mem[hdump] <= '0; // erase behind the read
            end
            rd <= mem[hdump]; // old value even when erased this cycle
        end
    end

    assign pxl = rd_sel ? g_bank[1].rd : g_bank[0].rd;

    // scanner stays idle until the clear is done
    a_no_wr_in_sweep: assert property (@(posedge clk) disable iff (rst)
        sweep |-> !wr.we);

endmodule

/* hw/obj_engine.sv */
`include "obj_params.svh"

module obj_engine (
    input  logic                             clk,
    input  logic                             rst,

    // object table load
    input  logic                             obj_we,
    input  logic [$clog2(`OBJ_COUNT)-1:0]    obj_addr,
    input  obj_gfx_pkg::obj_entry_t          obj_din,

    // palette PROM load
    input  logic                             prog_en,
    input  logic [7:0]                       prog_addr,
    input  obj_video_pkg::color_t            prog_data,

    // video timing
    input  logic                             hinit,
    input  obj_video_pkg::hpos_t             vrender,
    input  obj_video_pkg::hpos_t             hdump,
    input  logic                             pxl_cen,

    // graphics ROM
    output obj_gfx_pkg::rom_addr_t           rom_addr,
    output logic                             rom_cs,
    input  obj_gfx_pkg::rom_row_t            rom_data,
    input  logic                             rom_ok,

    output obj_video_pkg::color_t            pxl
);

    logic                    draw;
    logic                    busy;
    obj_gfx_pkg::draw_req_t  req;
    obj_video_pkg::buf_wr_t  wr;

    // decode, walks the table once per line
    obj_scan u_scan (
        .clk      (clk),
        .rst      (rst),
        .obj_we   (obj_we),
        .obj_addr (obj_addr),
        .obj_din  (obj_din),
        .hinit    (hinit),
        .vrender  (vrender),
        .busy     (busy),
        .draw     (draw),
        .req      (req)
    );

    // execute, one object row at a time
    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .draw     (draw),
        .req      (req),
        .busy     (busy),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .wr       (wr)
    );

    obj_line_buf u_buf (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr),
        .prog_en   (prog_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .hinit     (hinit),
        .hdump     (hdump),
        .pxl_cen   (pxl_cen),
        .pxl       (pxl)
    );

endmodule

/* tb/obj_rom_model.sv */
module obj_rom_model (
    input  logic                       clk,
    input  logic                       rst,
    input  obj_gfx_pkg::rom_addr_t     rom_addr,
    input  logic                       rom_cs,
    input  logic [2:0]                 rom_lat,   // wait for a new request, 1 to 4
    output obj_gfx_pkg::rom_row_t      rom_data,
    output logic                       rom_ok
);

    logic       pending;    // request seen, counting down
    logic [2:0] left;
    logic [2:0] remaining;  // cycles still to wait

    // nibble i is row plus i plus code
    function automatic obj_gfx_pkg::rom_row_t gfx_row(input obj_gfx_pkg::rom_addr_t a);
        obj_gfx_pkg::rom_row_t row;
        for (int i = 0; i < 8; i++) begin
            row[4*i +: 4] = 4'(a[3:0] + i + a[11:4]);
        end
        return row;
    endfunction

    assign remaining = pending ? left : rom_lat;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending  <= 1'b0;
            left     <= '0;
            rom_ok   <= 1'b0;
            rom_data <= '0;
        end else if (rom_ok) begin
            rom_ok  <= 1'b0; // cs drops on this same edge
            pending <= 1'b0;
        end else if (rom_cs) begin
            if (remaining <= 3'd1) begin
                rom_ok   <= 1'b1;
                rom_data <= gfx_row(rom_addr);
            end else begin
                pending <= 1'b1;
                left    <= remaining - 3'd1;
            end
        end
    end

endmodule

/* tb/obj_engine_tb.sv */
`include "obj_params.svh"

module obj_engine_tb;

    localparam int NUM_TESTS   = 7;
    localparam int LINE_CYCLES = 600; // one hinit period, longer than a full table draw
    localparam int ROW_CYCLES  = `OBJ_COUNT + `LINE_W + 2 * (LINE_CYCLES + 2);
    localparam int WATCHDOG    = 2 * (4 + NUM_TESTS * ROW_CYCLES);

    typedef struct packed {
        logic [7:0]                     line;      // vrender of this row
        logic [7:0]                     pal_seed;
        logic [4:0]                     nrand;     // random objects from slot 0 up
        logic [2:0]                     nfix;
        logic [3:0][4:0]                slot;      // table slot of each fixed object
        obj_gfx_pkg::obj_entry_t [3:0]  obj;
    } test_t;

    logic                     clk;
    logic                     rst;
    logic                     obj_we;
    logic [4:0]               obj_addr;
    obj_gfx_pkg::obj_entry_t  obj_din;
    logic                     prog_en;
    logic [7:0]               prog_addr;
    obj_video_pkg::color_t    prog_data;
    logic                     hinit;
    logic                     pxl_cen;
    obj_video_pkg::hpos_t     vrender;
    obj_video_pkg::hpos_t     hdump;
    obj_gfx_pkg::rom_addr_t   rom_addr;
    logic                     rom_cs;
    obj_gfx_pkg::rom_row_t    rom_data;
    logic                     rom_ok;
    logic [2:0]               rom_lat;
    obj_video_pkg::color_t    pxl;

    test_t                    tests [NUM_TESTS];
    obj_gfx_pkg::obj_entry_t  entries [`OBJ_COUNT]; // table image of the current row
    obj_video_pkg::color_t    ref_line [`LINE_W];   // line being drawn
    obj_video_pkg::color_t    shown [`LINE_W];      // what the read bank holds
    obj_gfx_pkg::rom_addr_t   line_fetch [$];       // rows the current table needs, in order
    obj_gfx_pkg::rom_addr_t   fetch_exp [$];        // rows still due on this line
    logic [15:0]              obj_st = 16'd53;
    logic [15:0]              rom_st = 16'd53;
    logic [7:0]               lat_bits;
    int                       color_errs;
    int                       busy_errs;
    int                       rom_errs;

    obj_engine dut_i (.*);
    obj_rom_model rom_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // 16-bit Galois LFSR step
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(inout logic [15:0] st, input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v  = {v[6:0], st[0]};
            st = lfsr_next(st);
        end
    endtask

    function automatic obj_video_pkg::color_t pal_value(input logic [7:0] a, input logic [7:0] seed);
        return a * 8'd37 + seed; // odd step, every address differs
    endfunction

    function automatic obj_gfx_pkg::obj_entry_t mk_obj(input logic [7:0] y, x, code,
            input logic [3:0] pal, input logic hf, vf);
        obj_gfx_pkg::obj_entry_t e;
        e       = '0; // spare bits stay clear
        e.ypos  = y;
        e.xpos  = x;
        e.code  = code;
        e.pal   = pal;
        e.hflip = hf;
        e.vflip = vf;
        return e;
    endfunction

    task automatic set_row(input int t, input logic [7:0] line, seed, input logic [4:0] nr);
        tests[t]          = '0;
        tests[t].line     = line;
        tests[t].pal_seed = seed;
        tests[t].nrand    = nr;
    endtask

    task automatic add_fix(input int t, input logic [4:0] slot, input obj_gfx_pkg::obj_entry_t e);
        tests[t].slot[tests[t].nfix] = slot;
        tests[t].obj[tests[t].nfix]  = e;
        tests[t].nfix++;
    endtask

    task automatic fill_tests();
        set_row(0, 8'd40, 8'h11, 5'd0);  // empty table
        set_row(1, 8'd77, 8'h5a, 5'd0);
        add_fix(1, 5'd5, mk_obj(8'd74, 8'd50, 8'h21, 4'd3, 1'b0, 1'b0));
        set_row(2, 8'd130, 8'hc3, 5'd0); // flips
        add_fix(2, 5'd2, mk_obj(8'd125, 8'd100, 8'h40, 4'd5, 1'b1, 1'b0));
        add_fix(2, 5'd9, mk_obj(8'd118, 8'd150, 8'h13, 4'd9, 1'b0, 1'b1));
        add_fix(2, 5'd20, mk_obj(8'd130, 8'd20, 8'h77, 4'd14, 1'b1, 1'b1));
        set_row(3, 8'd5, 8'h2e, 5'd0);   // overlap, wrap in x and y
        add_fix(3, 5'd3, mk_obj(8'd0, 8'd60, 8'h30, 4'd1, 1'b0, 1'b0));
        add_fix(3, 5'd7, mk_obj(8'd2, 8'd63, 8'h31, 4'd2, 1'b0, 1'b0));
        add_fix(3, 5'd12, mk_obj(8'd252, 8'd245, 8'h0f, 4'd10, 1'b1, 1'b0));
        add_fix(3, 5'd30, mk_obj(8'd250, 8'd250, 8'h52, 4'd6, 1'b0, 1'b1));
        set_row(4, 8'd99, 8'h87, 5'd12);
        set_row(5, 8'd200, 8'h3c, 5'd0); // blank line after a busy one
        set_row(6, 8'd180, 8'h64, 5'd24);
    endtask

    // table image and reference line for one row
    task automatic build_row(input test_t t);
        logic [7:0] v;
        logic [7:0] r;
        logic [3:0] ysub;
        logic [3:0] pix;
        logic [7:0] col;
        for (int k = 0; k < `OBJ_COUNT; k++) begin
            entries[k] = mk_obj(t.line + 8'd64, 8'd0, 8'd0, 4'd0, 1'b0, 1'b0); // off the line
        end
        for (int k = 0; k < t.nrand; k++) begin
            take_bits(obj_st, 4, v);
            entries[k].ypos = t.line - v; // always covers
            take_bits(obj_st, 8, v);
            entries[k].xpos = v;
            take_bits(obj_st, 8, v);
            entries[k].code = v;
            take_bits(obj_st, 6, v);
            entries[k].pal   = v[5:2];
            entries[k].hflip = v[1];
            entries[k].vflip = v[0];
        end
        for (int j = 0; j < t.nfix; j++) begin
            entries[t.slot[j]] = t.obj[j];
        end
        for (int c = 0; c < `LINE_W; c++) begin
            ref_line[c] = '0;
        end
        line_fetch.delete();
        for (int k = 0; k < `OBJ_COUNT; k++) begin // higher slots paint last
            r = t.line - entries[k].ypos;
            if (r < 8'd16) begin
                ysub = entries[k].vflip ? 4'(15 - r) : r[3:0];
                line_fetch.push_back({entries[k].code, ysub}); // code then row
                for (int i = 0; i < 8; i++) begin
                    pix = 4'(ysub + i + entries[k].code);
                    col = entries[k].xpos + 8'(`OBJ_HOFFSET) + 8'(entries[k].hflip ? 7 - i : i);
                    if (pix != 4'd0) begin
                        ref_line[col] = pal_value({entries[k].pal, pix}, t.pal_seed);
                    end
                end
            end
        end
    endtask

    task automatic load_row(input test_t t);
        for (int k = 0; k < `OBJ_COUNT; k++) begin
            @(negedge clk);
            obj_we   = 1'b1;
            obj_addr = 5'(k);
            obj_din  = entries[k];
        end
        for (int a = 0; a < 256; a++) begin
            @(negedge clk);
            obj_we    = 1'b0;
            prog_en   = 1'b1;
            prog_addr = 8'(a);
            prog_data = pal_value(8'(a), t.pal_seed);
        end
        @(negedge clk);
        prog_en = 1'b0;
        vrender = t.line;
    endtask

    task automatic check_color(input obj_video_pkg::hpos_t col, input obj_video_pkg::color_t got,
            input obj_video_pkg::color_t exp);
        if (got !== exp) begin
            color_errs++;
            $display("MISMATCH pxl at hdump 0x%02h: got 0x%02h, expected 0x%02h", col, got, exp);
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        if (got !== exp) begin
            busy_errs++;
            $display("MISMATCH busy at time %0t: got 0x%0h, expected 0x%0h", $time, got, exp);
        end
    endtask

    task automatic check_addr(input obj_gfx_pkg::rom_addr_t got,
            input obj_gfx_pkg::rom_addr_t exp);
        if (got !== exp) begin
            rom_errs++;
            $display("MISMATCH rom_addr at time %0t: got 0x%03h, expected 0x%03h",
                     $time, got, exp);
        end
    endtask

    // one hinit period, read bank swept out on the way
    task automatic run_line(input logic idle);
        obj_gfx_pkg::rom_addr_t exp_addr;
        @(negedge clk);
        check_busy(dut_i.busy, 1'b0); // last line done drawing
        fetch_exp = line_fetch;
        hinit = 1'b1;
        for (int c = 0; c < LINE_CYCLES; c++) begin
            @(negedge clk);
            hinit = 1'b0;
            if (idle) begin
                check_busy(dut_i.busy, 1'b0);
            end
            if (rom_cs && rom_ok) begin // row handed over this cycle
                if (fetch_exp.size() == 0) begin
                    rom_errs++;
                    $display("ROM fetch at time %0t with no covering object left", $time);
                end else begin
                    exp_addr = fetch_exp.pop_front();
                    check_addr(rom_addr, exp_addr);
                end
            end
            if (c >= 4 && c <= 4 + `LINE_W) begin
                if (c > 4) begin
                    check_color(8'(c - 5), pxl, shown[c - 5]); // address from last cycle
                end
                pxl_cen = (c < 4 + `LINE_W);
                hdump   = 8'(c - 4);
            end
        end
        if (fetch_exp.size() != 0) begin
            rom_errs++;
            $display("%0d covering objects were never fetched from ROM", fetch_exp.size());
        end
    endtask

    // fresh ROM latency each cycle, 1 to 4
    always @(negedge clk) begin
        take_bits(rom_st, 2, lat_bits);
        rom_lat = 3'(lat_bits[1:0]) + 3'd1;
    end

    initial begin
        rst        = 1'b1;
        obj_we     = 1'b0;
        obj_addr   = '0;
        obj_din    = '0;
        prog_en    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        hinit      = 1'b0;
        pxl_cen    = 1'b0;
        vrender    = '0;
        hdump      = '0;
        rom_lat    = 3'd1;
        color_errs = 0;
        busy_errs  = 0;
        rom_errs   = 0;
        fill_tests();
        for (int c = 0; c < `LINE_W; c++) begin
            ref_line[c] = '0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        foreach (tests[i]) begin
            shown = ref_line; // other bank still has the previous line
            build_row(tests[i]);
            load_row(tests[i]);
            run_line((tests[i].nfix == 0) && (tests[i].nrand == 0));
            shown = ref_line;
            run_line((tests[i].nfix == 0) && (tests[i].nrand == 0));
        end
        $display("errors: pxl %0d, busy %0d, rom_addr %0d", color_errs, busy_errs, rom_errs);
        if (color_errs + busy_errs + rom_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired, the run hung before all test rows finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hw
hw/obj_video_pkg.sv
hw/obj_gfx_pkg.sv
hw/obj_scan.sv
hw/obj_draw.sv
hw/obj_line_buf.sv
hw/obj_engine.sv
tb/obj_rom_model.sv
tb/obj_engine_tb.sv

/* Bender.yml */
package:
  name: obj_engine

export_include_dirs:
  - hw

sources:
  - target: any(hw, tb)
    include_dirs:
      - hw
    files:
      - hw/obj_video_pkg.sv
      - hw/obj_gfx_pkg.sv
      - hw/obj_scan.sv
      - hw/obj_draw.sv
      - hw/obj_line_buf.sv
      - hw/obj_engine.sv
  - target: tb
    files:
      - tb/obj_rom_model.sv
      - tb/obj_engine_tb.sv
